// File: source/trace_pkg.sv
// Shared sizes, Wishbone register map and record word layout for the pipeline trace unit
package trace_pkg;

    ////////////////////////////////////////////////////////////
    // Pipeline and trace field sizes
    ////////////////////////////////////////////////////////////
    localparam int num_stages = 5;          // Fetch, decode, execute, memory, write-back
    localparam int id_w       = 8;          // Sequence id, wraps
    localparam int cnt_w      = 8;          // Stall count, saturates
    localparam int evt_w      = 16;         // One stage event code

    // Stage slot numbers inside the flat event vector
    localparam int stg_fetch   = 0;
    localparam int stg_decode  = 1;
    localparam int stg_execute = 2;
    localparam int stg_memory  = 3;
    localparam int stg_wb      = 4;

    ////////////////////////////////////////////////////////////
    // Record buffer
    ////////////////////////////////////////////////////////////
    localparam int buf_depth = 8;                       // Complete records held
    localparam int rec_words = 3;                       // Words per record
    localparam int word_w    = 32;                      // Wishbone data width
    localparam int buf_ptr_w = $clog2(buf_depth);       // Record pointer
    localparam int buf_cnt_w = $clog2(buf_depth + 1);   // Count must reach buf_depth
    localparam int widx_w    = $clog2(rec_words);       // Word index in a record

    // Wishbone word addresses
    localparam logic [1:0] adr_status = 2'd0;   // Count low, overflow bit 31
    localparam logic [1:0] adr_data   = 2'd1;   // Next word of oldest record
    localparam logic [1:0] adr_clear  = 2'd2;   // Write clears overflow

    ////////////////////////////////////////////////////////////
    // Record word, two views of the same 32 bits
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [id_w-1:0]  id;           // Sequence id
        logic [cnt_w-1:0] stall_cnt;    // Cycles held in fetch and decode
        logic [evt_w-1:0] fetch_evt;    // Fetch stage code
    } trace_hdr_t;

    typedef struct packed {
        logic [evt_w-1:0] hi;           // Earlier stage
        logic [evt_w-1:0] lo;           // Later stage
    } trace_pair_t;

    // Word 0 in header view, words 1 and 2 in pair view
    typedef union packed {
        trace_hdr_t  hdr;
        trace_pair_t pair;
    } trace_word_u;

endpackage

// File: source/trace_link_if.sv
// Trace state of one instruction handed from one pipeline slot to the next
interface trace_link_if;

    import trace_pkg::*;

    logic                        valid;     // Slot holds a real instruction
    logic [id_w-1:0]             id;        // Sequence id from the issuer
    logic [cnt_w-1:0]            stall_cnt; // Stall cycles so far
    logic [num_stages*evt_w-1:0] events;    // Fetch code in the low slot

    // Driving side
    modport up (
        output valid,
        output id,
        output stall_cnt,
        output events
    );

    // Receiving side
    modport down (
        input valid,
        input id,
        input stall_cnt,
        input events
    );

endinterface

// File: source/trace_issue.sv
// Id issuer in front of the fetch slot, registers each fetched instruction with a new id
module trace_issue (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   fetch_valid,     // CPU fetched a new instruction
    input  logic   stall,           // Fetch and decode frozen
    trace_link_if.up out            // Entry toward the fetch slot
);

    import trace_pkg::*;

    ////////////////////////////////////////////////////////////
    // Entry register
    ////////////////////////////////////////////////////////////
    logic            valid_q;   // Entry waiting for the fetch slot
    logic [id_w-1:0] id_q;      // Id given to that entry
    logic [id_w-1:0] next_id;   // Id for the next fetch

    // Control state, frozen with the fetch slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            next_id <= '0;  // First instruction gets id 0
        end else if (!stall) begin
            valid_q <= fetch_valid;
            if (fetch_valid) begin
                next_id <= next_id + 1'b1;  // Wraps at id_w bits
            end
        end
    end

    // Id follows the entry, no reset needed
    always_ff @(posedge clk) begin
        if (!stall && fetch_valid) begin
            id_q <= next_id;
        end
    end

    ////////////////////////////////////////////////////////////
    // Link outputs
    ////////////////////////////////////////////////////////////

    // Nothing is handed on while fetch is held
    assign out.valid     = valid_q & ~stall;
    assign out.id        = id_q;
    assign out.stall_cnt = '0;  // Fresh instruction, no stall yet
    assign out.events    = '0;  // Slots fill in their own codes

endmodule

// File: source/trace_stage.sv
// One pipeline slot, follows an instruction's id, stall count and stage event codes
module trace_stage #(
    parameter int stage_index = 0                   // Event slot this stage writes
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        hold,       // Keep current entry
    input  logic [trace_pkg::evt_w-1:0] stage_evt,  // Code reported by this stage now
    trace_link_if.down                  in,         // From upstream slot
    trace_link_if.up                    out         // To downstream slot
);

    import trace_pkg::*;

    ////////////////////////////////////////////////////////////
    // Slot registers
    ////////////////////////////////////////////////////////////
    logic                        valid_q;
    logic [cnt_w-1:0]            cnt_q;
    logic [id_w-1:0]             id_q;
    logic [num_stages*evt_w-1:0] evt_q;
    logic                        cnt_max;   // Count at saturation

    assign cnt_max = (cnt_q == {cnt_w{1'b1}});

    // Valid bit and stall count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else if (hold) begin
            // Held instruction pays one stall cycle
            if (valid_q && !cnt_max) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else begin
            valid_q <= in.valid;    // Bubble when upstream is held
            cnt_q   <= in.valid ? in.stall_cnt : '0;
        end
    end

    // Id and earlier stage codes move with the entry
    always_ff @(posedge clk) begin
        if (!hold) begin
            id_q  <= in.id;
            evt_q <= in.events;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs toward the next slot
    ////////////////////////////////////////////////////////////

    // Own code is taken live, so the last cycle in the slot wins
    always_comb begin
        out.valid     = valid_q & ~hold;    // Downstream sees a bubble while held
        out.id        = id_q;
        out.stall_cnt = cnt_q;
        out.events    = evt_q;
        if (valid_q) begin
            out.events[stage_index*evt_w +: evt_w] = stage_evt;
        end
    end

endmodule

// File: source/trace_buffer.sv
// Record buffer after write-back, packs retired entries and serves them on a Wishbone slave
module trace_buffer (
    input  logic                         clk,
    input  logic                         rst_n,
    trace_link_if.down                   in,        // Retiring entry from write-back
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [1:0]                   wb_adr,
    input  logic [trace_pkg::word_w-1:0] wb_dat_w,
    output logic [trace_pkg::word_w-1:0] wb_dat_r,
    output logic                         wb_ack
);

    import trace_pkg::*;

    ////////////////////////////////////////////////////////////
    // Record store
    ////////////////////////////////////////////////////////////
    trace_word_u          mem [buf_depth][rec_words];  // Circular store of records
    trace_word_u          rec [rec_words];             // Incoming record, packed
    logic [buf_ptr_w-1:0] wr_ptr;
    logic [buf_ptr_w-1:0] rd_ptr;
    logic [buf_cnt_w-1:0] count;        // Complete records held
    logic [widx_w-1:0]    word_idx;     // Next word of the oldest record
    logic                 overflow;     // Sticky, record lost while full
    logic [word_w-1:0]    scratch;      // Last word written to adr_clear

    logic full;
    logic empty;
    logic push;     // Record accepted this cycle
    logic drop;     // Record lost this cycle
    logic pop;      // Last word of oldest record read

    // Wishbone decode
    logic req;      // New request, not yet acked
    logic access;   // Register operation on the ack cycle
    logic data_rd;
    logic clr_wr;

    assign full  = (count == buf_cnt_w'(buf_depth));
    assign empty = (count == '0);

    // Header word, then decode and execute, then memory and write-back
    always_comb begin
        rec[0].hdr.id        = in.id;
        rec[0].hdr.stall_cnt = in.stall_cnt;
        rec[0].hdr.fetch_evt = in.events[stg_fetch*evt_w +: evt_w];
        rec[1].pair.hi       = in.events[stg_decode*evt_w +: evt_w];
        rec[1].pair.lo       = in.events[stg_execute*evt_w +: evt_w];
        rec[2].pair.hi       = in.events[stg_memory*evt_w +: evt_w];
        rec[2].pair.lo       = in.events[stg_wb*evt_w +: evt_w];
    end

    ////////////////////////////////////////////////////////////
    // Wishbone classic handshake
    ////////////////////////////////////////////////////////////
    assign req     = wb_cyc & wb_stb & ~wb_ack;     // Accept only while ack is low
    assign access  = wb_ack & wb_cyc & wb_stb;
    assign data_rd = access & ~wb_we & (wb_adr == adr_data);
    assign clr_wr  = access & wb_we & (wb_adr == adr_clear);

    assign push = in.valid & ~full;
    assign drop = in.valid & full;  // Pipeline never waits on the buffer
    assign pop  = data_rd & ~empty & (word_idx == widx_w'(rec_words - 1));

    // Ack one cycle after the request, for one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers, count and flags
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            word_idx <= '0;
            overflow <= 1'b0;
            scratch  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // buf_depth is a power of two
            end
            if (data_rd && !empty) begin
                word_idx <= pop ? '0 : word_idx + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
            if (clr_wr) begin
                overflow <= 1'b0;
                scratch  <= wb_dat_w;
            end
            if (drop) begin
                overflow <= 1'b1;   // Set wins over clear in the same cycle
            end
        end
    end

    // Record payload, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            for (int w = 0; w < rec_words; w++) begin
                mem[wr_ptr][w] <= rec[w];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (wb_adr)
            adr_status: wb_dat_r = {overflow, {(word_w-1-buf_cnt_w){1'b0}}, count};
            adr_data:   wb_dat_r = empty ? '0 : mem[rd_ptr][word_idx];  // Empty reads zero
            adr_clear:  wb_dat_r = scratch;
            default:    wb_dat_r = '0;
        endcase
    end

endmodule

// File: source/trace_top.sv
// Top level of the trace unit, issuer and five stage slots feeding the Wishbone record buffer
module trace_top (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          fetch_valid,  // New fetch
    input  logic                                          stall,        // Fetch and decode held
    input  logic [trace_pkg::num_stages*trace_pkg::evt_w-1:0] stage_evt, // Fetch code lowest
    input  logic                                          wb_cyc,
    input  logic                                          wb_stb,
    input  logic                                          wb_we,
    input  logic [1:0]                                    wb_adr,
    input  logic [trace_pkg::word_w-1:0]                  wb_dat_w,
    output logic [trace_pkg::word_w-1:0]                  wb_dat_r,
    output logic                                          wb_ack
);

    import trace_pkg::*;

    ////////////////////////////////////////////////////////////
    // Links, 0 from the issuer, 5 into the buffer
    ////////////////////////////////////////////////////////////
    trace_link_if link [num_stages+1] ();

    trace_issue trace_issue_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .out         (link[0].up)
    );

    ////////////////////////////////////////////////////////////
    // Stage slots
    ////////////////////////////////////////////////////////////
    genvar k;
    generate
        for (k = 0; k < num_stages; k++) begin : g_stage
            // Only fetch and decode stall, execute onward always moves
            trace_stage #(
                .stage_index (k)
            ) trace_stage_inst (
                .clk       (clk),
                .rst_n     (rst_n),
                .hold      ((k <= stg_decode) ? stall : 1'b0),
                .stage_evt (stage_evt[k*evt_w +: evt_w]),
                .in        (link[k].down),
                .out       (link[k+1].up)
            );
        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // Record buffer and host port
    ////////////////////////////////////////////////////////////
    trace_buffer trace_buffer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (link[num_stages].down),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

// File: sim/trace_checker.sv
// Concurrent assertions bound into the trace unit, covering the Wishbone slave and held slots
module trace_checker (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            wb_cyc,
    input logic                            wb_stb,
    input logic                            wb_ack,
    input logic [trace_pkg::buf_cnt_w-1:0] level,       // Records held in the buffer
    input logic                            hold,        // Slot frozen this cycle
    input logic                            slot_valid,
    input logic [trace_pkg::id_w-1:0]      slot_id
);

    import trace_pkg::*;

    int fail_count = 0;     // Assertion failures in this instance

    ////////////////////////////////////////////////////////////
    // Wishbone slave
    ////////////////////////////////////////////////////////////

    // Ack answers a request seen while ack was low
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
        else begin
            $error("wb_ack without a request in the cycle before");
            fail_count++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)     // Single-cycle ack
        else begin
            $error("wb_ack high for more than one cycle");
            fail_count++;
        end

    count_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        level <= buf_cnt_w'(buf_depth))
        else begin
            $error("record count above buffer depth");
            fail_count++;
        end

    ////////////////////////////////////////////////////////////
    // Stage slots
    ////////////////////////////////////////////////////////////
    held_id_stable: assert property (@(posedge clk) disable iff (!rst_n)
        hold && slot_valid |=> slot_id == $past(slot_id))
        else begin
            $error("held slot changed its id");
            fail_count++;
        end

endmodule

// Buffer side, slot inputs tied off
bind trace_buffer trace_checker bus_check_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .level      (count),
    .hold       (1'b0),
    .slot_valid (1'b0),
    .slot_id    ('0)
);

// Every stage slot, bus inputs tied off
bind trace_stage trace_checker slot_check_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (1'b0),
    .wb_stb     (1'b0),
    .wb_ack     (1'b0),
    .level      ('0),
    .hold       (hold),
    .slot_valid (valid_q),
    .slot_id    (id_q)
);

// File: sim/trace_monitor.sv
// Reference model of the trace unit, predicts each record and checks every Wishbone read
module trace_monitor (
    input logic                                               clk,
    input logic                                               rst_n,
    input logic                                               fetch_valid,
    input logic                                               stall,
    input logic [trace_pkg::num_stages*trace_pkg::evt_w-1:0]  stage_evt,
    input logic                                               wb_cyc,
    input logic                                               wb_stb,
    input logic                                               wb_we,
    input logic [1:0]                                         wb_adr,
    input logic [trace_pkg::word_w-1:0]                       wb_dat_r,
    input logic                                               wb_ack
);

    import trace_pkg::*;

    typedef struct packed {
        logic                        valid;
        logic [id_w-1:0]             id;
        logic [cnt_w-1:0]            cnt;
        logic [num_stages*evt_w-1:0] evt;   // Fetch code lowest
    } entry_t;

    string             test_name = "";      // Set by the testbench top
    int                err_count = 0;
    int                check_count = 0;
    entry_t            pipe [num_stages+1]; // 0 is the issuer, then fetch to write-back
    logic [id_w-1:0]   next_id;
    logic [word_w-1:0] exp_q [$];           // Expected buffer contents, one entry per word
    logic              exp_ovf;

    // A partly read record still counts as held
    function automatic int records();
        return (exp_q.size() + rec_words - 1) / rec_words;
    endfunction

    task automatic compare(input string what, input logic [word_w-1:0] exp, act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One model step per rising edge
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin : step
        trace_word_u w [rec_words];
        logic        was_full;
        logic        was_empty;
        logic        access;
        was_full  = (records() == buf_depth);   // Pop in this cycle frees nothing yet
        was_empty = (exp_q.size() == 0);
        access    = wb_ack && wb_cyc && wb_stb;
        if (!rst_n) begin
            foreach (pipe[i]) pipe[i] = '0;
            next_id = '0;
            exp_q.delete();
            exp_ovf = 1'b0;
        end else begin
            // Host side, acted on in the ack cycle
            if (access && !wb_we && wb_adr == adr_status) begin
                compare("status", {exp_ovf, 31'(records())}, wb_dat_r);
            end
            if (access && !wb_we && wb_adr == adr_data) begin
                compare("data", was_empty ? 32'h0 : exp_q[0], wb_dat_r);
                if (!was_empty) void'(exp_q.pop_front());
            end
            if (access && wb_we && wb_adr == adr_clear) exp_ovf = 1'b0;

            // Last code seen in a slot wins
            for (int k = 0; k < num_stages; k++) begin
                if (pipe[k+1].valid)
                    pipe[k+1].evt[k*evt_w +: evt_w] = stage_evt[k*evt_w +: evt_w];
            end

            // Retire from write-back
            if (pipe[num_stages].valid) begin
                w[0].hdr.id        = pipe[num_stages].id;
                w[0].hdr.stall_cnt = pipe[num_stages].cnt;
                w[0].hdr.fetch_evt = pipe[num_stages].evt[0 +: evt_w];
                w[1].pair.hi       = pipe[num_stages].evt[1*evt_w +: evt_w];
                w[1].pair.lo       = pipe[num_stages].evt[2*evt_w +: evt_w];
                w[2].pair.hi       = pipe[num_stages].evt[3*evt_w +: evt_w];
                w[2].pair.lo       = pipe[num_stages].evt[4*evt_w +: evt_w];
                if (was_full) exp_ovf = 1'b1;   // Dropped, overflow beats a clear
                else foreach (w[i]) exp_q.push_back(w[i]);
            end

            // Execute onward always moves
            pipe[5] = pipe[4];
            pipe[4] = pipe[3];
            if (stall) begin
                pipe[3] = '0;   // Bubble into execute
                for (int k = 1; k <= 2; k++) begin
                    if (pipe[k].valid && pipe[k].cnt != '1) pipe[k].cnt++;
                end
            end else begin
                pipe[3]       = pipe[2];
                pipe[2]       = pipe[1];
                pipe[1]       = pipe[0];
                pipe[0]       = '0;
                pipe[0].valid = fetch_valid;
                pipe[0].id    = next_id;
                if (fetch_valid) next_id++;     // Wraps at id_w
            end
        end
    end

endmodule

// File: sim/trace_tb.sv
// Testbench top, runs a stimulus table through the trace unit and drains records over Wishbone
module trace_tb;

    import trace_pkg::*;

    localparam int num_rows     = 17;
    localparam int ack_timeout  = 16;               // Cycles allowed for wb_ack
    localparam int flush_cycles = num_stages + 2;   // Issuer plus slots, then into the buffer
    localparam int drain_limit  = buf_depth + 2;    // Status rounds before giving up

    typedef struct {
        logic  fv;
        int    stall_mode;  // 0 low, 1 high, 2 random
        int    cycles;
        string name;
    } row_t;

    // Consecutive rows with one name make one test
    row_t rows [num_rows] = '{
        '{1'b0, 0, 1,   "reset"},
        '{1'b1, 0, 6,   "stream"},
        '{1'b1, 0, 1,   "stall"},
        '{1'b1, 1, 3,   "stall"},
        '{1'b1, 0, 2,   "stall"},
        '{1'b0, 1, 2,   "stall"},
        '{1'b1, 0, 1,   "stall"},
        '{1'b1, 0, 1,   "saturate"},
        '{1'b0, 0, 1,   "saturate"},
        '{1'b0, 1, 300, "saturate"},    // Well past the 8-bit count
        '{1'b0, 0, 1,   "saturate"},
        '{1'b1, 0, 2,   "gap"},
        '{1'b0, 0, 3,   "gap"},
        '{1'b1, 0, 2,   "gap"},
        '{1'b0, 0, 1,   "gap"},
        '{1'b1, 0, 1,   "gap"},
        '{1'b1, 2, 20,  "overflow"}
    };

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        fetch_valid;
    logic                        stall;
    logic [num_stages*evt_w-1:0] stage_evt;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [1:0]                  wb_adr;
    logic [word_w-1:0]           wb_dat_w;
    logic [word_w-1:0]           wb_dat_r;
    logic                        wb_ack;
    int                          tick;          // Per-cycle part of each event code
    int                          timeouts;
    int                          tests_run;
    int                          tests_failed;
    string                       cur_name;

    always #20 clk = ~clk;

    trace_top trace_top_inst (.*);
    trace_monitor trace_monitor_inst (.*);

    // Failures of the bound assertions in the buffer and all five slots
    function automatic int assertion_failures();
        return trace_top_inst.trace_buffer_inst.bus_check_inst.fail_count
             + trace_top_inst.g_stage[0].trace_stage_inst.slot_check_inst.fail_count
             + trace_top_inst.g_stage[1].trace_stage_inst.slot_check_inst.fail_count
             + trace_top_inst.g_stage[2].trace_stage_inst.slot_check_inst.fail_count
             + trace_top_inst.g_stage[3].trace_stage_inst.slot_check_inst.fail_count
             + trace_top_inst.g_stage[4].trace_stage_inst.slot_check_inst.fail_count;
    endfunction

    ////////////////////////////////////////////////////////////
    // Drivers, called at a falling edge
    ////////////////////////////////////////////////////////////
    task automatic drive_cycle(input logic fv, input logic st);
        fetch_valid = fv;
        stall       = st;
        for (int k = 0; k < num_stages; k++) begin
            stage_evt[k*evt_w +: evt_w] = {4'(k + 1), 12'(tick)};   // Stage number on top
        end
        tick++;
        @(negedge clk);
    endtask

    task automatic bus_access(input logic we, input logic [1:0] adr,
                              input logic [word_w-1:0] wdata, output logic [word_w-1:0] rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            timeouts++;
            $display("Timeout in test %s: no wb_ack after %0d cycles", cur_name, ack_timeout);
        end
        @(negedge clk);     // Strobe stays up through the ack cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Read every record, then an empty read, clear overflow and read status again
    task automatic drain_records();
        logic [word_w-1:0] status;
        logic [word_w-1:0] word;
        int                rounds;
        rounds = 0;
        bus_access(1'b0, adr_status, '0, status);
        while (status[buf_cnt_w-1:0] != '0 && rounds < drain_limit) begin
            for (int w = 0; w < rec_words; w++) bus_access(1'b0, adr_data, '0, word);
            bus_access(1'b0, adr_status, '0, status);
            rounds++;
        end
        if (status[buf_cnt_w-1:0] != '0) begin
            timeouts++;
            $display("Test %s: buffer still not empty after %0d records", cur_name, rounds);
        end
        bus_access(1'b0, adr_data, '0, word);
        bus_access(1'b1, adr_clear, 32'h0, word);
        bus_access(1'b0, adr_status, '0, status);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        string next_name;
        int    err_start;
        int    chk_start;
        int    tmo_start;
        int    asrt_start;
        int    errs;
        logic  st;
        void'($urandom(32'h19fd));
        rst_n = 1'b0;
        fetch_valid = 1'b0;
        stall = 1'b0;
        stage_evt = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        tick = 0;
        timeouts = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < num_rows; r++) begin
            if (r == 0 || rows[r].name != rows[r-1].name) begin
                cur_name = rows[r].name;
                trace_monitor_inst.test_name = cur_name;
                err_start = trace_monitor_inst.err_count;
                chk_start = trace_monitor_inst.check_count;
                tmo_start = timeouts;
                asrt_start = assertion_failures();
            end
            for (int c = 0; c < rows[r].cycles; c++) begin
                if (rows[r].stall_mode == 2) st = ($urandom % 4) == 0;
                else st = rows[r].stall_mode[0];
                drive_cycle(rows[r].fv, st);
            end
            next_name = (r + 1 < num_rows) ? rows[r+1].name : "";
            if (next_name != cur_name) begin
                repeat (flush_cycles) drive_cycle(1'b0, 1'b0);
                drain_records();
                errs = trace_monitor_inst.err_count - err_start + timeouts - tmo_start
                     + assertion_failures() - asrt_start;
                tests_run++;
                if (errs != 0) tests_failed++;
                $display("Test %s: %0d checks, %0d errors", cur_name,
                         trace_monitor_inst.check_count - chk_start, errs);
            end
        end
        $display("Tests %0d, failed %0d, checks %0d, errors %0d, timeouts %0d, assertions %0d",
                 tests_run, tests_failed, trace_monitor_inst.check_count,
                 trace_monitor_inst.err_count, timeouts, assertion_failures());
        if (tests_failed == 0 && trace_monitor_inst.err_count == 0 && timeouts == 0
            && assertion_failures() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: trace.f
source/trace_pkg.sv
source/trace_link_if.sv
source/trace_issue.sv
source/trace_stage.sv
source/trace_buffer.sv
source/trace_top.sv
sim/trace_checker.sv
sim/trace_monitor.sv
sim/trace_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = trace_tb
RTL_TOP    = trace_top
FILELIST   = trace.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
